// ==== Makefile ====
VERILATOR  ?= verilator
FILELIST   ?= build.f
TOP        ?= minesweeper_core_tb
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
rtl/mine_pkg.sv
rtl/dim_counter.sv
rtl/mine_board.sv
rtl/cell_command_decode.sv
rtl/neighbor_execute.sv
rtl/game_status.sv
rtl/minesweeper_core.sv
tests/minesweeper_core_tb.sv

// ==== rtl/cell_command_decode.sv ====
`timescale 1ns/100ps

module cell_command_decode
    import mine_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cmd_strobe,
    input  cell_cmd_t cmd,
    input  coord_t    dim,
    input  game_e     state,
    output logic      dec_valid,
    output cell_cmd_t dec_cmd
);

    logic in_field;
    logic accept;

    // The hard field fills the store, so every coordinate fits there.
    assign in_field = (cmd.row <= dim) && (cmd.col <= dim);

    // This is the only place a command can be dropped.
    assign accept = cmd_strobe && in_field && (state == game_playing);

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_cmd <= cmd;  // Held until the next accepted command.
        end
    end

endmodule

// ==== rtl/dim_counter.sv ====
`timescale 1ns/100ps

module dim_counter
    import mine_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   enable,
    input  coord_t dim,     // Side of the active field minus one.
    output coord_t row,
    output coord_t col,
    output logic   wrap
);

    // Last cell of the pass while the counter is stepping.
    assign wrap = enable && (row == dim) && (col == dim);

    // Column runs fastest and the row steps at the end of each line.
    always_ff @(posedge clk) begin
        if (rst) begin
            row <= '0;
            col <= '0;
        end else if (enable) begin
            if (col == dim) begin
                col <= '0;
                if (wrap) begin
                    row <= '0;  // Pass complete, start again at the top left.
                end else begin
                    row <= row + coord_t'(1);
                end
            end else begin
                col <= col + coord_t'(1);
            end
        end
    end

endmodule

// ==== rtl/game_status.sv ====
`timescale 1ns/100ps

module game_status
    import mine_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_game,
    input  logic                       board_ready,
    input  logic                       result_strobe,
    input  cell_result_t               result,
    input  mine_count_t                mine_total,
    input  coord_t                     dim,
    output logic [max_dim*max_dim-1:0] revealed,
    output game_e                      state
);

    logic [7:0]  cell_idx;
    logic        mine_hit;
    logic        reveal_hit;
    cell_count_t side;
    cell_count_t target;
    cell_count_t safe_count;

    assign cell_idx = {result.row, result.col};

    // Flag results and blocked reveals both carry the flagged bit.
    assign mine_hit   = result_strobe && !result.flagged && result.mine;
    assign reveal_hit = result_strobe && !result.flagged && !result.mine && !revealed[cell_idx];

    // Safe cells still hidden when the game starts.
    assign side   = cell_count_t'(dim) + cell_count_t'(1);
    assign target = side * side - cell_count_t'(mine_total);

    // ==============================
    // Game FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= game_idle;
        end else if (new_game) begin
            state <= game_generating;
        end else begin
            case (state)
                game_generating: if (board_ready) state <= game_playing;
                game_playing: begin
                    if (mine_hit) begin
                        state <= game_lost;
                    end else if (reveal_hit && (safe_count + cell_count_t'(1) == target)) begin
                        state <= game_won;
                    end
                end
                default: state <= state;  // Lost and won wait for the next game.
            endcase
        end
    end

    // A cell counts once, however often it is revealed.
    always_ff @(posedge clk) begin
        if (rst || new_game) begin
            revealed   <= '0;
            safe_count <= '0;
        end else if (state == game_playing && reveal_hit) begin
            revealed[cell_idx] <= 1'b1;
            safe_count         <= safe_count + cell_count_t'(1);
        end
    end

endmodule

// ==== rtl/mine_board.sv ====
`timescale 1ns/100ps

module mine_board
    import mine_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         new_game,
    input  level_e                       level,
    input  mine_count_t                  mines,
    input  lfsr_t                        seed,
    input  coord_t                       rd_row,
    input  coord_t                       rd_col,
    output logic [max_dim*max_dim-1:0]   board,
    output coord_t                       dim,
    output mine_count_t                  mine_total,
    output logic                         board_ready
);

    gen_e                       gen_state;
    lfsr_t                      lfsr;
    lfsr_t                      lfsr_next;
    logic [max_dim*max_dim-1:0] store;
    mine_count_t                placed;
    mine_count_t                placed_next;
    coord_t                     scan_row;
    coord_t                     scan_col;
    logic                       wrap;
    logic                       place;
    coord_t                     new_dim;
    cell_count_t                side;
    cell_count_t                max_mines;
    mine_count_t                mines_clamped;

    // ==============================
    // Settings sampled at new_game
    // ==============================
    always_comb begin
        case (level)
            level_medium: new_dim = coord_t'(medium_dim - 1);
            level_hard:   new_dim = coord_t'(hard_dim - 1);
            default:      new_dim = coord_t'(easy_dim - 1);
        endcase
        side      = cell_count_t'(new_dim) + cell_count_t'(1);
        max_mines = side * side - cell_count_t'(1);
        // At least one safe cell must remain or the game could never be won.
        if (cell_count_t'(mines) > max_mines) begin
            mines_clamped = mine_count_t'(max_mines);
        end else begin
            mines_clamped = mines;
        end
    end

    dim_counter u_scan (
        .clk    (clk),
        .rst    (rst || new_game),
        .enable (gen_state == gen_scan),
        .dim    (dim),
        .row    (scan_row),
        .col    (scan_col),
        .wrap   (wrap)
    );

    // One Galois step per scanned cell.
    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ lfsr_poly) : (lfsr >> 1);

    assign place = (lfsr_next[3:0] < mine_threshold)
                && !store[{scan_row, scan_col}]
                && (placed < mine_total);

    assign placed_next = placed + mine_count_t'(place);

    // ==============================
    // Generator FSM
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            gen_state  <= gen_idle;
            placed     <= '0;
            dim        <= coord_t'(easy_dim - 1);
            mine_total <= '0;
        end else if (new_game) begin
            gen_state  <= gen_scan;
            placed     <= '0;
            dim        <= new_dim;
            mine_total <= mines_clamped;
        end else if (gen_state == gen_scan) begin
            placed <= placed_next;
            // An empty request still runs one full pass before it reports ready.
            if ((placed_next == mine_total) && (place || wrap)) begin
                gen_state <= gen_done;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (new_game) begin
            lfsr  <= (seed == '0) ? lfsr_t'(1) : seed;  // The all-zero state would lock up.
            store <= '0;
        end else if (gen_state == gen_scan) begin
            lfsr <= lfsr_next;
            if (place) begin
                store[{scan_row, scan_col}] <= 1'b1;
            end
        end
    end

    assign board_ready = (gen_state == gen_done);

    // Only the 3x3 window around the read cell is exposed to the execute stage.
    always_comb begin
        for (int r = 0; r < max_dim; r++) begin
            for (int c = 0; c < max_dim; c++) begin
                board[r*max_dim + c] = store[r*max_dim + c]
                    && (r >= int'(rd_row) - 1) && (r <= int'(rd_row) + 1)
                    && (c >= int'(rd_col) - 1) && (c <= int'(rd_col) + 1);
            end
        end
    end

endmodule

// ==== rtl/mine_pkg.sv ====
package mine_pkg;

    // ==============================
    // Field geometry
    // ==============================
    localparam int max_dim    = 16;  // Side of the board store.
    localparam int easy_dim   = 8;
    localparam int medium_dim = 10;
    localparam int hard_dim   = 16;

    // ==============================
    // Plain vector types
    // ==============================
    typedef logic [3:0]  coord_t;       // Row or column index.
    typedef logic [7:0]  mine_count_t;  // Never more than one less than the cell count.
    typedef logic [8:0]  cell_count_t;  // Holds 256 for the hard field.
    typedef logic [3:0]  neighbor_t;
    typedef logic [15:0] lfsr_t;

    // Galois taps for x^16 + x^14 + x^13 + x^11 + 1 in the right-shifting form.
    localparam lfsr_t lfsr_poly = 16'hB400;

    // A cell gets a mine when the low nibble of the shift register is below this.
    localparam logic [3:0] mine_threshold = 4'd3;

    // ==============================
    // Enumerations
    // ==============================
    typedef enum logic [1:0] {
        level_easy,
        level_medium,
        level_hard
    } level_e;

    typedef enum logic {
        cmd_reveal,
        cmd_flag
    } cmd_e;

    typedef enum logic [2:0] {
        game_idle,
        game_generating,
        game_playing,
        game_lost,
        game_won
    } game_e;

    // Board generator states.
    typedef enum logic [1:0] {
        gen_idle,
        gen_scan,
        gen_done
    } gen_e;

    // ==============================
    // Command and result records
    // ==============================
    typedef struct packed {
        cmd_e   kind;
        coord_t row;
        coord_t col;
    } cell_cmd_t;

    typedef struct packed {
        coord_t    row;
        coord_t    col;
        logic      mine;
        logic      flagged;           // Set on every flag result and on a blocked reveal.
        logic      already_revealed;
        neighbor_t neighbors;
    } cell_result_t;

endpackage

// ==== rtl/minesweeper_core.sv ====
`timescale 1ns/100ps

module minesweeper_core
    import mine_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         new_game,
    input  level_e       level,
    input  mine_count_t  mines,
    input  lfsr_t        seed,
    input  logic         cmd_strobe,
    input  cell_cmd_t    cmd,
    output logic         board_ready,
    output logic         result_strobe,
    output cell_result_t result,
    output game_e        state
);

    logic [max_dim*max_dim-1:0] board;
    logic [max_dim*max_dim-1:0] revealed;
    coord_t                     dim;
    mine_count_t                mine_total;
    logic                       dec_valid;
    cell_cmd_t                  dec_cmd;

    // ==============================
    // Board generation
    // ==============================
    mine_board u_board (
        .clk         (clk),
        .rst         (rst),
        .new_game    (new_game),
        .level       (level),
        .mines       (mines),
        .seed        (seed),
        .rd_row      (dec_cmd.row),  // Reads follow the command in the execute stage.
        .rd_col      (dec_cmd.col),
        .board       (board),
        .dim         (dim),
        .mine_total  (mine_total),
        .board_ready (board_ready)
    );

    // ==============================
    // Command pipeline
    // ==============================
    cell_command_decode u_decode (
        .clk        (clk),
        .rst        (rst),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .dim        (dim),
        .state      (state),
        .dec_valid  (dec_valid),
        .dec_cmd    (dec_cmd)
    );

    neighbor_execute u_execute (
        .clk           (clk),
        .rst           (rst),
        .new_game      (new_game),
        .dec_valid     (dec_valid),
        .dec_cmd       (dec_cmd),
        .board         (board),
        .dim           (dim),
        .revealed      (revealed),
        .result_strobe (result_strobe),
        .result        (result)
    );

    game_status u_status (
        .clk           (clk),
        .rst           (rst),
        .new_game      (new_game),
        .board_ready   (board_ready),
        .result_strobe (result_strobe),
        .result        (result),
        .mine_total    (mine_total),
        .dim           (dim),
        .revealed      (revealed),
        .state         (state)
    );

endmodule

// ==== rtl/neighbor_execute.sv ====
`timescale 1ns/100ps

module neighbor_execute
    import mine_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       new_game,
    input  logic                       dec_valid,
    input  cell_cmd_t                  dec_cmd,
    input  logic [max_dim*max_dim-1:0] board,
    input  coord_t                     dim,
    input  logic [max_dim*max_dim-1:0] revealed,
    output logic                       result_strobe,
    output cell_result_t               result
);

    logic [max_dim*max_dim-1:0] flags;
    logic [7:0]                 cell_idx;
    logic                       is_flagged;
    logic                       prior_reveal;
    logic                       was_revealed;
    neighbor_t                  nb_count;

    assign cell_idx   = {dec_cmd.row, dec_cmd.col};
    assign is_flagged = flags[cell_idx];

    // The status stage writes its map one cycle after the result, so a reveal of
    // the same cell just ahead of this one is caught here.
    assign prior_reveal = result_strobe && !result.flagged && !result.mine
                       && (result.row == dec_cmd.row) && (result.col == dec_cmd.col);
    assign was_revealed = revealed[cell_idx] || prior_reveal;

    // ==============================
    // 3x3 neighbour count
    // ==============================
    always_comb begin
        int r;
        int c;
        nb_count = '0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                r = int'(dec_cmd.row) + dr;
                c = int'(dec_cmd.col) + dc;
                // Skip the cell itself and anything past the active edge.
                if ((dr != 0 || dc != 0) && r >= 0 && c >= 0
                        && r <= int'(dim) && c <= int'(dim)) begin
                    nb_count = nb_count + neighbor_t'(board[r*max_dim + c]);
                end
            end
        end
    end

    // Flags on revealed cells are ignored.
    always_ff @(posedge clk) begin
        if (rst || new_game) begin
            flags <= '0;
        end else if (dec_valid && dec_cmd.kind == cmd_flag && !was_revealed) begin
            flags[cell_idx] <= !is_flagged;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            result_strobe <= 1'b0;
        end else begin
            result_strobe <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            result.row              <= dec_cmd.row;
            result.col              <= dec_cmd.col;
            result.already_revealed <= was_revealed;
            if (dec_cmd.kind == cmd_flag) begin
                result.mine      <= 1'b0;
                result.flagged   <= 1'b1;  // Marks the result as a flag action.
                result.neighbors <= '0;
            end else begin
                result.mine      <= board[cell_idx] && !is_flagged;
                result.flagged   <= is_flagged;
                result.neighbors <= is_flagged ? neighbor_t'(0) : nb_count;
            end
        end
    end

endmodule

// ==== tests/minesweeper_core_tb.sv ====
`timescale 1ns/100ps

module minesweeper_core_tb
    import mine_pkg::*;
();

    localparam int ready_timeout = 4000;  // Cycles allowed for board generation.

    logic         clk;
    logic         rst;
    logic         new_game;
    level_e       level;
    mine_count_t  mines;
    lfsr_t        seed;
    logic         cmd_strobe;
    cell_cmd_t    cmd;
    logic         board_ready;
    logic         result_strobe;
    cell_result_t result;
    game_e        state;

    logic [15:0]  mine_rows [16];  // Expected layout where bit c of entry r is cell (r,c).
    logic [15:0]  shown_rows [16]; // Safe cells revealed so far.
    int           side;
    int           safe_expected;
    int           shown_count;
    logic         pipe_valid [2];
    cell_result_t pipe_exp [2];
    integer       rand_seed;

    minesweeper_core dut (
        .clk           (clk),
        .rst           (rst),
        .new_game      (new_game),
        .level         (level),
        .mines         (mines),
        .seed          (seed),
        .cmd_strobe    (cmd_strobe),
        .cmd           (cmd),
        .board_ready   (board_ready),
        .result_strobe (result_strobe),
        .result        (result),
        .state         (state)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ==============================
    // Reporting and compare tasks
    // ==============================
    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("ERROR at %0t: %s", $time, msg));
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) report_mismatch($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    task automatic check_state(input game_e exp);
        if (state !== exp) report_mismatch($sformatf("state is %s, expected %s",
                                                     state.name(), exp.name()));
    endtask

    task automatic check_result(input cell_result_t exp);
        if (result !== exp) begin
            report_mismatch($sformatf(
                "result (%0d,%0d) mine %b flag %b rev %b nb %0d, expected (%0d,%0d) %b %b %b %0d",
                result.row, result.col, result.mine, result.flagged,
                result.already_revealed, result.neighbors, exp.row, exp.col, exp.mine,
                exp.flagged, exp.already_revealed, exp.neighbors));
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================
    // One falling edge. A result must appear exactly two cycles after its accepted strobe.
    task automatic step(input logic drive, input cell_cmd_t c, input logic acc,
                        input cell_result_t e);
        @(negedge clk);
        check_bit(result_strobe, pipe_valid[1], "result_strobe");
        if (pipe_valid[1]) check_result(pipe_exp[1]);
        pipe_valid[1] = pipe_valid[0];
        pipe_exp[1]   = pipe_exp[0];
        pipe_valid[0] = drive && acc;
        pipe_exp[0]   = e;
        cmd_strobe    = drive;
        cmd           = c;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) step(1'b0, '0, 1'b0, '0);
    endtask

    // Neighbour count taken from the expected layout, limited to the active field.
    function automatic int count_adjacent(input int r, input int c);
        int n;
        n = 0;
        for (int rr = r - 1; rr <= r + 1; rr++) begin
            for (int cc = c - 1; cc <= c + 1; cc++) begin
                if ((rr != r || cc != c) && rr >= 0 && cc >= 0 && rr < side && cc < side) begin
                    n += int'(mine_rows[rr][cc]);
                end
            end
        end
        return n;
    endfunction

    task automatic start_game(input int lv, input int mn, input lfsr_t sd);
        int n;
        for (int r = 0; r < 16; r++) begin
            mine_rows[r]  = '0;
            shown_rows[r] = '0;
        end
        side        = (lv == 2) ? hard_dim : ((lv == 1) ? medium_dim : easy_dim);
        shown_count = 0;
        @(negedge clk);
        new_game = 1'b1;
        level    = level_e'(lv);
        mines    = mine_count_t'(mn);
        seed     = sd;
        @(negedge clk);
        new_game = 1'b0;
        n = 0;
        while (!board_ready) begin
            if (n == ready_timeout) stop_run("board_ready did not rise before the timeout");
            n++;
            @(negedge clk);
        end
        @(negedge clk);
        check_state(game_playing);
    endtask

    // Reveals every hidden safe cell with random gaps, so some strobes come back to back.
    task automatic sweep_field();
        cell_result_t e;
        integer       gap;
        for (int r = 0; r < side; r++) begin
            for (int c = 0; c < side; c++) begin
                if (!mine_rows[r][c] && !shown_rows[r][c]) begin
                    gap = $random(rand_seed);
                    if (gap[0]) idle_cycles(1);
                    e = '{row: coord_t'(r), col: coord_t'(c), mine: 1'b0, flagged: 1'b0,
                          already_revealed: 1'b0, neighbors: neighbor_t'(count_adjacent(r, c))};
                    step(1'b1, '{kind: cmd_reveal, row: coord_t'(r), col: coord_t'(c)}, 1'b1, e);
                    shown_rows[r][c] = 1'b1;
                    shown_count++;
                end
            end
        end
        idle_cycles(3);
        check_state(game_won);
        if (shown_count != safe_expected) begin
            report_mismatch($sformatf("%0d safe cells, expected %0d", shown_count, safe_expected));
        end
    endtask

    // ==============================
    // Vector file
    // ==============================
    initial begin
        int            fd;
        int            code;
        logic [15:0]   tag;
        logic [1599:0] line_buf;
        int            a;
        int            b;
        int            k;
        int            r;
        int            c;
        int            acc;
        int            st;
        int            e_mine;
        int            e_flag;
        int            e_rev;
        int            e_nb;
        lfsr_t         sd;
        logic [15:0]   mask;
        cell_result_t  e;
        rand_seed  = 32'h4305_200c;
        rst        = 1'b1;
        new_game   = 1'b0;
        level      = level_easy;
        mines      = '0;
        seed       = '0;
        cmd_strobe = 1'b0;
        cmd        = '0;
        pipe_valid[0] = 1'b0;
        pipe_valid[1] = 1'b0;
        pipe_exp[0]   = '0;
        pipe_exp[1]   = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_state(game_idle);
        check_bit(board_ready, 1'b0, "board_ready");
        check_bit(result_strobe, 1'b0, "result_strobe");
        fd = $fopen("tests/minesweeper_vectors.txt", "r");
        if (fd == 0) stop_run("could not open tests/minesweeper_vectors.txt");
        while ($fscanf(fd, "%s", tag) == 1) begin
            if (tag == "#") begin
                code = $fgets(line_buf, fd);
            end else if (tag == "G") begin
                code = $fscanf(fd, "%d %d %h %d", a, b, sd, safe_expected);
                if (code != 4) stop_run("malformed game line in the vector file");
                start_game(a, b, sd);
            end else if (tag == "R") begin
                code = $fscanf(fd, "%d %h", r, mask);
                if (code != 2) stop_run("malformed row line in the vector file");
                mine_rows[r] = mask;
            end else if (tag == "C") begin
                code = $fscanf(fd, "%d %d %d %d %d %d %d %d %d",
                               k, r, c, acc, e_mine, e_flag, e_rev, e_nb, st);
                if (code != 9) stop_run("malformed command line in the vector file");
                e = '{row: coord_t'(r), col: coord_t'(c), mine: e_mine[0], flagged: e_flag[0],
                      already_revealed: e_rev[0], neighbors: neighbor_t'(e_nb)};
                step(1'b1, '{kind: cmd_e'(k), row: coord_t'(r), col: coord_t'(c)}, acc[0], e);
                idle_cycles(4);
                check_state(game_e'(st));
                if (acc != 0 && k == 0 && e_flag == 0 && e_mine == 0 && !shown_rows[r][c]) begin
                    shown_rows[r][c] = 1'b1;
                    shown_count++;
                end
            end else if (tag == "W") begin
                sweep_field();
            end else begin
                stop_run("unknown line type in the vector file");
            end
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// ==== tests/minesweeper_vectors.txt ====
# G level mines seed_hex safe_cells | R row mine_mask_hex | W reveal all hidden safe cells
# C kind row col accepted mine flagged revealed neighbors state (2 playing, 3 lost, 4 won)
G 0 9 0004 55
R 0 00ff
R 1 0001
C 0 1 1 1 0 0 0 4 2
C 0 1 1 1 0 0 1 4 2
C 1 2 2 1 0 1 0 0 2
C 0 2 2 1 0 1 0 0 2
C 1 2 2 1 0 1 0 0 2
C 0 2 2 1 0 0 0 0 2
C 0 1 7 1 0 0 0 2 2
C 0 9 0 0 0 0 0 0 2
W
C 0 3 3 0 0 0 0 0 4
G 1 3 0000 97
R 0 0007
C 0 9 9 1 0 0 0 0 2
C 0 1 1 1 0 0 0 3 2
C 0 10 0 0 0 0 0 0 2
W
C 1 0 5 0 0 0 0 0 4
G 2 9 0004 247
R 0 01ff
C 0 15 15 1 0 0 0 0 2
C 0 1 9 1 0 0 0 1 2
C 0 1 0 1 0 0 0 2 2
C 0 0 4 1 1 0 0 2 3
C 0 2 2 0 0 0 0 0 3
